// File: all.f
logic/dmi_pkg.sv
logic/mem_map_pkg.sv
logic/dmi_port_select.sv
logic/dmi_fifo.sv
logic/mem_target.sv
logic/debug_mem_top.sv
dv/debug_mem_sva.sv
dv/tb_debug_mem.sv

// File: dv/tb_debug_mem.sv
`timescale 1ns/10ps

module tb_debug_mem;

  import dmi_pkg::*;
  import mem_map_pkg::*;

  localparam int unsigned FifoDepth     = 4;
  localparam int unsigned TestCycles    = 400;
  localparam int unsigned TimeoutCycles = 5 * TestCycles;

  logic clk_i;
  logic rst_ni;
  logic jtag_sel_i;
  logic req_valid_jtag_i, req_ready_jtag_o, resp_valid_jtag_o, resp_ready_jtag_i;
  logic req_valid_dmi_i, req_ready_dmi_o, resp_valid_dmi_o, resp_ready_dmi_i;
  dmi_req_t  req_jtag_i, req_dmi_i;
  dmi_resp_t resp_jtag_o, resp_dmi_o;

  // expected responses per port, in request order
  dmi_resp_t   jtag_exp_q[$];
  dmi_resp_t   dmi_exp_q[$];
  logic [31:0] ram_model [RamWords];
  logic [15:0] lfsr_q;
  bit          jtag_mode;
  int unsigned cycle_cnt;
  int unsigned err_cnt, err_mark, test_idx, pass_cnt, fail_cnt;

  debug_mem_top #(
    .FifoDepth ( FifoDepth ),
    .RamWords  ( RamWords  )
  ) debug_mem_top_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // random source and reference model
  // ----------------------------------------
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // top ram word is left unwritten on purpose
  function automatic logic [6:0] rand_ram_addr();
    return RamBase + 7'(rand_bits(6) % (RamWords - 1));
  endfunction

  function automatic dmi_req_t make_req(input logic [6:0] addr, input dmi_op_e op,
                                        input logic [31:0] data);
    dmi_req_t r;
    r.addr = addr;
    r.op   = op;
    r.data = data;
    return r;
  endfunction

  function automatic dmi_resp_t model_resp(input dmi_req_t r);
    dmi_resp_t e;
    logic      in_rom;
    logic      in_ram;
    in_rom = r.addr < RomBase + RomWords;
    in_ram = (r.addr >= RamBase) && (r.addr < RamBase + RamWords);
    e.data = '0;
    e.resp = DMI_SUCCESS;
    if (r.op == DMI_READ && in_rom) begin
      e.data = RomSignature | {25'b0, r.addr};
    end else if (r.op == DMI_READ && in_ram) begin
      e.data = ram_model[r.addr - RamBase];
    end else if (r.op == DMI_WRITE && in_ram) begin
      ram_model[r.addr - RamBase] = r.data;
    end else if (r.op != DMI_NOP) begin
      e.resp = DMI_FAILED;
    end
    return e;
  endfunction

  // ----------------------------------------
  // drivers
  // ----------------------------------------
  task automatic send_req(input bit use_jtag, input dmi_req_t r);
    @(posedge clk_i);
    if (use_jtag) begin
      req_valid_jtag_i <= 1'b1;
      req_jtag_i       <= r;
    end else begin
      req_valid_dmi_i <= 1'b1;
      req_dmi_i       <= r;
    end
    do @(negedge clk_i); while (!(use_jtag ? req_ready_jtag_o : req_ready_dmi_o));
    // accepted on the coming edge
    if (use_jtag) jtag_exp_q.push_back(model_resp(r));
    else dmi_exp_q.push_back(model_resp(r));
  endtask

  task automatic end_burst(input bit use_jtag);
    @(posedge clk_i);
    if (use_jtag) req_valid_jtag_i <= 1'b0;
    else req_valid_dmi_i <= 1'b0;
  endtask

  task automatic drain_responses();
    while (jtag_exp_q.size() != 0 || dmi_exp_q.size() != 0) @(negedge clk_i);
    @(posedge clk_i);
  endtask

  // own checks plus failures of the bound assertions
  function automatic int unsigned error_total();
    return err_cnt + debug_mem_top_inst.debug_mem_sva_inst.err_cnt;
  endfunction

  task automatic finish_test(input string name);
    drain_responses();
    test_idx++;
    if (error_total() == err_mark) begin
      pass_cnt++;
      $display("test %0d %s: ok", test_idx, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: %0d error(s)", test_idx, name, error_total() - err_mark);
    end
    err_mark = error_total();
  endtask

  // ----------------------------------------
  // response checking
  // ----------------------------------------
  task automatic check_resp(input string name, input dmi_resp_t exp, input dmi_resp_t got);
    assert (got.data === exp.data) else begin
      $display("Fail at %0t: %s.data expected %h, got %h", $time, name, exp.data, got.data);
      err_cnt++;
    end
    assert (got.resp === exp.resp) else begin
      $display("Fail at %0t: %s.resp expected %h, got %h", $time, name, exp.resp, got.resp);
      err_cnt++;
    end
  endtask

  task automatic take_resp(input string name, ref dmi_resp_t q[$], input dmi_resp_t got);
    assert (q.size() > 0) else begin
      $display("response on %s at %0t with none outstanding", name, $time);
      err_cnt++;
    end
    if (q.size() > 0) check_resp(name, q.pop_front(), got);
  endtask

  always @(negedge clk_i) begin
    if (resp_valid_jtag_o && resp_ready_jtag_i) take_resp("resp_jtag_o", jtag_exp_q, resp_jtag_o);
    if (resp_valid_dmi_o && resp_ready_dmi_i) take_resp("resp_dmi_o", dmi_exp_q, resp_dmi_o);
    if (jtag_mode) begin
      assert (!req_ready_dmi_o) else begin
        $display("dmi port saw ready at %0t while jtag owns the bus", $time);
        err_cnt++;
      end
      assert (!resp_valid_dmi_o) else begin
        $display("dmi port saw a response at %0t while jtag owns the bus", $time);
        err_cnt++;
      end
    end
  end

  // watchdog
  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  initial begin
    wait (cycle_cnt >= TimeoutCycles);
    $display("timeout: run did not finish within %0d cycles", TimeoutCycles);
    $display("TB FAILED");
    $finish;
  end

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    logic [6:0] addrs [6];
    rst_ni = 1'b0;
    jtag_sel_i = 1'b0;
    req_valid_jtag_i = 1'b0;
    req_jtag_i = '0;
    resp_ready_jtag_i = 1'b1;
    req_valid_dmi_i = 1'b0;
    req_dmi_i = '0;
    resp_ready_dmi_i = 1'b1;
    lfsr_q = 16'd52;
    foreach (ram_model[i]) ram_model[i] = '0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;

    for (int i = 0; i < 6; i++) begin
      addrs[i] = rand_ram_addr();
      send_req(0, make_req(addrs[i], DMI_WRITE, rand_bits(32)));
    end
    for (int i = 0; i < 6; i++) send_req(0, make_req(addrs[i], DMI_READ, '0));
    send_req(0, make_req(7'(RamBase + RamWords - 1), DMI_READ, '0));
    end_burst(0);
    finish_test("ram write and read back");

    for (int a = 0; a < RomWords; a++) send_req(0, make_req(7'(a), DMI_READ, '0));
    send_req(0, make_req(7'h05, DMI_WRITE, 32'hdeadbeef));
    send_req(0, make_req(7'h05, DMI_READ, '0));
    end_burst(0);
    finish_test("boot rom");

    // dmi responses held back for a few cycles
    resp_ready_dmi_i <= 1'b0;
    send_req(0, make_req(7'h40, DMI_READ, '0));
    send_req(0, make_req(7'h55, DMI_WRITE, 32'h12345678));
    send_req(0, make_req(7'h7f, DMI_READ, '0));
    send_req(0, make_req(7'h12, DMI_RESERVED, 32'hffffffff));
    send_req(0, make_req(7'h20, DMI_NOP, 32'h0000abcd));
    end_burst(0);
    repeat (4) @(posedge clk_i);
    resp_ready_dmi_i <= 1'b1;
    finish_test("unmapped, reserved op and nop");

    // switch owner with nothing in flight
    @(posedge clk_i);
    jtag_sel_i <= 1'b1;
    repeat (3) @(posedge clk_i);
    jtag_mode = 1'b1;
    req_valid_dmi_i <= 1'b1;
    req_dmi_i <= make_req(7'h11, DMI_READ, '0);
    for (int i = 0; i < 6; i++) begin
      addrs[i] = rand_ram_addr();
      send_req(1, make_req(addrs[i], DMI_WRITE, rand_bits(32)));
    end
    for (int i = 0; i < 6; i++) send_req(1, make_req(addrs[i], DMI_READ, '0));
    end_burst(1);
    req_valid_dmi_i <= 1'b0;
    finish_test("jtag transport");

    @(posedge clk_i);
    resp_ready_jtag_i <= 1'b0;
    fork
      begin
        for (int i = 0; i < 6; i++) begin
          addrs[i] = rand_ram_addr();
          send_req(1, make_req(addrs[i], DMI_WRITE, rand_bits(32)));
          send_req(1, make_req(addrs[i], DMI_READ, '0));
        end
        end_burst(1);
      end
      begin
        repeat (30) @(negedge clk_i);
        assert (!req_ready_jtag_o) else begin
          $display("request path never stalled with responses blocked");
          err_cnt++;
        end
        @(posedge clk_i);
        resp_ready_jtag_i <= 1'b1;
      end
    join
    finish_test("back-pressure");

    $display("tests run: %0d, passed: %0d, failed: %0d", test_idx, pass_cnt, fail_cnt);
    if (fail_cnt == 0 && error_total() == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: dv/debug_mem_sva.sv
`timescale 1ns/10ps

module debug_mem_sva (
  input logic               clk_i,
  input logic               rst_ni,
  input logic               req_valid_jtag_i,
  input dmi_pkg::dmi_req_t  req_jtag_i,
  input logic               req_ready_jtag_o,
  input logic               resp_valid_jtag_o,
  input dmi_pkg::dmi_resp_t resp_jtag_o,
  input logic               resp_ready_jtag_i,
  input logic               req_valid_dmi_i,
  input dmi_pkg::dmi_req_t  req_dmi_i,
  input logic               req_ready_dmi_o,
  input logic               resp_valid_dmi_o,
  input dmi_pkg::dmi_resp_t resp_dmi_o,
  input logic               resp_ready_dmi_i
);

  int          jtag_open;
  int          dmi_open;
  int unsigned err_cnt;

  // ----------------------------------------
  // ownership
  // ----------------------------------------
  // requests taken minus responses returned, per port
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      jtag_open <= 0;
      dmi_open  <= 0;
    end else begin
      jtag_open <= jtag_open + int'(req_valid_jtag_i && req_ready_jtag_o)
                 - int'(resp_valid_jtag_o && resp_ready_jtag_i);
      dmi_open  <= dmi_open + int'(req_valid_dmi_i && req_ready_dmi_o)
                 - int'(resp_valid_dmi_o && resp_ready_dmi_i);
    end
  end

  // a response only shows up on the port whose requests are in flight
  jtag_resp_owned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_jtag_o |-> jtag_open > 0)
    else begin
      $error("response valid on the jtag port with no jtag request in flight");
      err_cnt++;
    end

  dmi_resp_owned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_dmi_o |-> dmi_open > 0)
    else begin
      $error("response valid on the dmi port with no dmi request in flight");
      err_cnt++;
    end

  // ----------------------------------------
  // link stability
  // ----------------------------------------
  jtag_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_jtag_i && !req_ready_jtag_o |=> $stable(req_jtag_i))
    else begin
      $error("jtag request changed while stalled");
      err_cnt++;
    end

  dmi_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_dmi_i && !req_ready_dmi_o |=> $stable(req_dmi_i))
    else begin
      $error("dmi request changed while stalled");
      err_cnt++;
    end

  jtag_resp_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_jtag_o && !resp_ready_jtag_i |=> $stable(resp_jtag_o))
    else begin
      $error("jtag response changed while stalled");
      err_cnt++;
    end

  dmi_resp_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_dmi_o && !resp_ready_dmi_i |=> $stable(resp_dmi_o))
    else begin
      $error("dmi response changed while stalled");
      err_cnt++;
    end

  // first cycle out of reset
  reset_quiet: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !resp_valid_jtag_o && !resp_valid_dmi_o)
    else begin
      $error("response valid in the first cycle after reset");
      err_cnt++;
    end

endmodule

bind debug_mem_top debug_mem_sva debug_mem_sva_inst (.*);

// File: logic/debug_mem_top.sv
`timescale 1ns/10ps

module debug_mem_top #(
  parameter int unsigned FifoDepth = 4,
  parameter int unsigned RamWords  = mem_map_pkg::RamWords
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               jtag_sel_i,
  // jtag transport
  input  logic               req_valid_jtag_i,
  input  dmi_pkg::dmi_req_t  req_jtag_i,
  output logic               req_ready_jtag_o,
  output logic               resp_valid_jtag_o,
  output dmi_pkg::dmi_resp_t resp_jtag_o,
  input  logic               resp_ready_jtag_i,
  // dmi transport
  input  logic               req_valid_dmi_i,
  input  dmi_pkg::dmi_req_t  req_dmi_i,
  output logic               req_ready_dmi_o,
  output logic               resp_valid_dmi_o,
  output dmi_pkg::dmi_resp_t resp_dmi_o,
  input  logic               resp_ready_dmi_i
);

  import dmi_pkg::*;

  // selector to request fifo
  logic      sel_req_valid;
  dmi_req_t  sel_req;
  logic      sel_req_ready;
  // request fifo to target
  logic      tgt_req_valid;
  dmi_req_t  tgt_req;
  logic      tgt_req_ready;
  // target to response fifo
  logic      tgt_resp_valid;
  dmi_resp_t tgt_resp;
  logic      tgt_resp_ready;
  // response fifo to selector
  logic      sel_resp_valid;
  dmi_resp_t sel_resp;
  logic      sel_resp_ready;

  // ----------------------------------------
  // transport selector
  // ----------------------------------------
  dmi_port_select #(
    .MaxOutstanding ( 2 * FifoDepth + 1 )
  ) dmi_port_select_inst (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .jtag_sel_i        ( jtag_sel_i        ),
    .req_valid_jtag_i  ( req_valid_jtag_i  ),
    .req_jtag_i        ( req_jtag_i        ),
    .req_ready_jtag_o  ( req_ready_jtag_o  ),
    .resp_valid_jtag_o ( resp_valid_jtag_o ),
    .resp_jtag_o       ( resp_jtag_o       ),
    .resp_ready_jtag_i ( resp_ready_jtag_i ),
    .req_valid_dmi_i   ( req_valid_dmi_i   ),
    .req_dmi_i         ( req_dmi_i         ),
    .req_ready_dmi_o   ( req_ready_dmi_o   ),
    .resp_valid_dmi_o  ( resp_valid_dmi_o  ),
    .resp_dmi_o        ( resp_dmi_o        ),
    .resp_ready_dmi_i  ( resp_ready_dmi_i  ),
    .req_valid_o       ( sel_req_valid     ),
    .req_o             ( sel_req           ),
    .req_ready_i       ( sel_req_ready     ),
    .resp_valid_i      ( sel_resp_valid    ),
    .resp_i            ( sel_resp          ),
    .resp_ready_o      ( sel_resp_ready    )
  );

  // ----------------------------------------
  // request and response queues
  // ----------------------------------------
  dmi_fifo #(
    .payload_t ( dmi_req_t ),
    .Depth     ( FifoDepth )
  ) req_fifo_inst (
    .clk_i       ( clk_i         ),
    .rst_ni      ( rst_ni        ),
    .in_valid_i  ( sel_req_valid ),
    .in_data_i   ( sel_req       ),
    .in_ready_o  ( sel_req_ready ),
    .out_valid_o ( tgt_req_valid ),
    .out_data_o  ( tgt_req       ),
    .out_ready_i ( tgt_req_ready )
  );

  dmi_fifo #(
    .payload_t ( dmi_resp_t ),
    .Depth     ( FifoDepth  )
  ) resp_fifo_inst (
    .clk_i       ( clk_i          ),
    .rst_ni      ( rst_ni         ),
    .in_valid_i  ( tgt_resp_valid ),
    .in_data_i   ( tgt_resp       ),
    .in_ready_o  ( tgt_resp_ready ),
    .out_valid_o ( sel_resp_valid ),
    .out_data_o  ( sel_resp       ),
    .out_ready_i ( sel_resp_ready )
  );

  // ----------------------------------------
  // memory target
  // ----------------------------------------
  mem_target #(
    .RamWords ( RamWords )
  ) mem_target_inst (
    .clk_i        ( clk_i          ),
    .rst_ni       ( rst_ni         ),
    .req_valid_i  ( tgt_req_valid  ),
    .req_i        ( tgt_req        ),
    .req_ready_o  ( tgt_req_ready  ),
    .resp_valid_o ( tgt_resp_valid ),
    .resp_o       ( tgt_resp       ),
    .resp_ready_i ( tgt_resp_ready )
  );

endmodule

// File: logic/mem_target.sv
`timescale 1ns/10ps

module mem_target #(
  parameter int unsigned RamWords = mem_map_pkg::RamWords
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_valid_i,
  input  dmi_pkg::dmi_req_t  req_i,
  output logic               req_ready_o,
  output logic               resp_valid_o,
  output dmi_pkg::dmi_resp_t resp_o,
  input  logic               resp_ready_i
);

  import dmi_pkg::*;
  import mem_map_pkg::*;

  localparam int unsigned IdxWidth = (RamWords > 1) ? $clog2(RamWords) : 1;

  logic [DmiDataWidth-1:0] ram_q [RamWords];
  logic [IdxWidth-1:0]     ram_idx;
  logic                    is_rom;
  logic                    is_ram;
  logic                    ram_we;
  logic                    accept;
  dmi_resp_t               resp_d;
  dmi_resp_t               resp_q;
  logic                    resp_valid_q;

  // a stalled response blocks new requests
  assign req_ready_o = ~resp_valid_q | resp_ready_i;
  assign accept      = req_valid_i & req_ready_o;

  assign resp_valid_o = resp_valid_q;
  assign resp_o       = resp_q;

  // ----------------------------------------
  // address decode
  // ----------------------------------------
  assign is_rom  = (req_i.addr >= RomBase) && (req_i.addr < RomBase + RomWords);
  assign is_ram  = (req_i.addr >= RamBase) && (req_i.addr < RamBase + RamWords);
  assign ram_idx = IdxWidth'(req_i.addr - RamBase);

  always_comb begin
    resp_d.data = '0;
    resp_d.resp = DMI_SUCCESS;
    ram_we      = 1'b0;
    unique case (req_i.op)
      DMI_NOP: begin
        resp_d.resp = DMI_SUCCESS;
      end
      DMI_READ: begin
        if (is_rom) begin
          resp_d.data = rom_word(req_i.addr);
        end else if (is_ram) begin
          resp_d.data = ram_q[ram_idx];
        end else begin
          resp_d.resp = DMI_FAILED;
        end
      end
      DMI_WRITE: begin
        if (is_ram) begin
          ram_we = accept;
        end else begin
          // rom or unmapped
          resp_d.resp = DMI_FAILED;
        end
      end
      default: begin
        resp_d.resp = DMI_FAILED;
      end
    endcase
  end

  // ----------------------------------------
  // storage and response register
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ram_q <= '{default: '0};
    end else if (ram_we) begin
      ram_q[ram_idx] <= req_i.data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_q <= 1'b0;
    end else if (accept) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_q <= resp_d;
    end
  end

endmodule

// File: logic/dmi_fifo.sv
`timescale 1ns/10ps

module dmi_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned Depth     = 4
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     in_valid_i,
  input  payload_t in_data_i,
  output logic     in_ready_o,
  output logic     out_valid_o,
  output payload_t out_data_o,
  input  logic     out_ready_i
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  payload_t            mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic [CntWidth-1:0] count_d;
  logic                in_ready_q;
  logic                out_valid_q;
  logic                push;
  logic                pop;

  // wrap at Depth, which need not be a power of two
  function automatic logic [PtrWidth-1:0] next_ptr(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(Depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign push = in_valid_i & in_ready_q;
  assign pop  = out_valid_q & out_ready_i;

  assign in_ready_o  = in_ready_q;
  assign out_valid_o = out_valid_q;
  assign out_data_o  = mem_q[rd_ptr_q];

  always_comb begin
    count_d = count_q;
    if (push && !pop) begin
      count_d = count_q + 1'b1;
    end else if (pop && !push) begin
      count_d = count_q - 1'b1;
    end
  end

  // ----------------------------------------
  // pointers and registered flags
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      count_q     <= '0;
      in_ready_q  <= 1'b0;
      out_valid_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      count_q     <= count_d;
      in_ready_q  <= (count_d != CntWidth'(Depth));
      out_valid_q <= (count_d != '0);
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data_i;
    end
  end

endmodule

// File: logic/dmi_port_select.sv
`timescale 1ns/10ps

module dmi_port_select #(
  parameter int unsigned MaxOutstanding = 9
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                jtag_sel_i,
  // jtag transport
  input  logic                req_valid_jtag_i,
  input  dmi_pkg::dmi_req_t   req_jtag_i,
  output logic                req_ready_jtag_o,
  output logic                resp_valid_jtag_o,
  output dmi_pkg::dmi_resp_t  resp_jtag_o,
  input  logic                resp_ready_jtag_i,
  // dmi transport
  input  logic                req_valid_dmi_i,
  input  dmi_pkg::dmi_req_t   req_dmi_i,
  output logic                req_ready_dmi_o,
  output logic                resp_valid_dmi_o,
  output dmi_pkg::dmi_resp_t  resp_dmi_o,
  input  logic                resp_ready_dmi_i,
  // toward the request fifo
  output logic                req_valid_o,
  output dmi_pkg::dmi_req_t   req_o,
  input  logic                req_ready_i,
  // from the response fifo
  input  logic                resp_valid_i,
  input  dmi_pkg::dmi_resp_t  resp_i,
  output logic                resp_ready_o
);

  localparam int unsigned CntWidth = $clog2(MaxOutstanding + 1);

  logic                jtag_owner_q;
  logic                jtag_owner_d;
  logic [CntWidth-1:0] cnt_q;
  logic [CntWidth-1:0] cnt_d;
  logic                req_fire;
  logic                resp_fire;

  // ----------------------------------------
  // routing
  // ----------------------------------------
  assign req_valid_o  = jtag_owner_q ? req_valid_jtag_i  : req_valid_dmi_i;
  assign req_o        = jtag_owner_q ? req_jtag_i        : req_dmi_i;
  assign resp_ready_o = jtag_owner_q ? resp_ready_jtag_i : resp_ready_dmi_i;

  // the idle port sees no ready and no response
  assign req_ready_jtag_o  = jtag_owner_q & req_ready_i;
  assign req_ready_dmi_o   = ~jtag_owner_q & req_ready_i;
  assign resp_valid_jtag_o = jtag_owner_q & resp_valid_i;
  assign resp_valid_dmi_o  = ~jtag_owner_q & resp_valid_i;

  // payload goes to both, valid qualifies it
  assign resp_jtag_o = resp_i;
  assign resp_dmi_o  = resp_i;

  // ----------------------------------------
  // outstanding count and owner
  // ----------------------------------------
  assign req_fire  = req_valid_o & req_ready_i;
  assign resp_fire = resp_valid_i & resp_ready_o;

  always_comb begin
    cnt_d = cnt_q;
    if (req_fire && !resp_fire) begin
      cnt_d = cnt_q + 1'b1;
    end else if (resp_fire && !req_fire) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  // switch only with nothing in flight, not even a request taken now
  assign jtag_owner_d = (cnt_q == '0 && !req_fire) ? jtag_sel_i : jtag_owner_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      jtag_owner_q <= 1'b0;
      cnt_q        <= '0;
    end else begin
      jtag_owner_q <= jtag_owner_d;
      cnt_q        <= cnt_d;
    end
  end

endmodule

// File: logic/mem_map_pkg.sv
package mem_map_pkg;

  // ----------------------------------------
  // debug bus address map, in words
  // ----------------------------------------
  // boot rom, read only
  localparam logic [dmi_pkg::DmiAddrWidth-1:0] RomBase = 7'h00;
  localparam int unsigned RomWords = 16;

  // scratch ram, read/write
  localparam logic [dmi_pkg::DmiAddrWidth-1:0] RamBase = 7'h10;
  localparam int unsigned RamWords = 48;

  // everything from 0x40 up is unmapped

  // ----------------------------------------
  // boot rom content
  // ----------------------------------------
  localparam logic [dmi_pkg::DmiDataWidth-1:0] RomSignature = 32'hB0070000;

  // signature with the word address in the low bits
  function automatic logic [dmi_pkg::DmiDataWidth-1:0] rom_word(
    input logic [dmi_pkg::DmiAddrWidth-1:0] addr
  );
    return RomSignature | dmi_pkg::DmiDataWidth'(addr);
  endfunction

endpackage

// File: logic/dmi_pkg.sv
package dmi_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------
  localparam int unsigned DmiAddrWidth = 7;
  localparam int unsigned DmiDataWidth = 32;

  // ----------------------------------------
  // op and response codes
  // ----------------------------------------
  typedef enum logic [1:0] {
    DMI_NOP      = 2'd0,
    DMI_READ     = 2'd1,
    DMI_WRITE    = 2'd2,
    DMI_RESERVED = 2'd3
  } dmi_op_e;

  // 1 and 3 are not produced by the target
  typedef enum logic [1:0] {
    DMI_SUCCESS = 2'd0,
    DMI_FAILED  = 2'd2
  } dmi_resp_e;

  // ----------------------------------------
  // link payloads
  // ----------------------------------------
  // 41 bits
  typedef struct packed {
    logic [DmiAddrWidth-1:0] addr;
    dmi_op_e                 op;
    logic [DmiDataWidth-1:0] data;
  } dmi_req_t;

  // 34 bits
  typedef struct packed {
    logic [DmiDataWidth-1:0] data;
    dmi_resp_e               resp;
  } dmi_resp_t;

endpackage
